/* dv/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb import lsq_pkg::*; ();

    typedef enum {OP_IDLE, OP_STORE, OP_LOAD, OP_COMMIT, OP_FLUSH, OP_HOLD, OP_RELEASE} op_e;

    typedef struct {
        op_e         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0]  f3;
        logic [3:0]  rob;
        logic        hit;            // Loads only
        logic [31:0] exp;
        int          after_drains;   // Load result may not come before this many drains
    } row_t;

    typedef struct {
        logic        hit;
        logic [31:0] data;
        int          after_drains;
    } ld_exp_t;

    typedef struct {
        logic [31:0] addr;
        logic [31:0] data;
        logic [2:0]  f3;
    } wr_exp_t;

    logic                 clk;
    logic                 arst_n;
    logic                 req_valid, req_is_store, req_is_load;
    logic [XLEN-1:0]      req_addr, req_data;
    logic [2:0]           req_funct3;
    logic [ROB_IDX_W-1:0] req_rob_idx;
    logic                 req_credit;
    logic                 commit_valid;
    logic [ROB_IDX_W-1:0] commit_rob_idx;
    logic                 flush;
    logic                 ld_valid, ld_hit;
    logic [XLEN-1:0]      ld_data;
    logic                 cw_valid;
    logic [XLEN-1:0]      cw_addr, cw_data;
    logic [2:0]           cw_funct3;
    logic                 cw_credit;

    row_t    rows[$];
    ld_exp_t ld_q[$];
    wr_exp_t wr_exp[$];
    int      wr_idx     = 0;
    int      up_credits = REQ_Q_DEPTH;   // Upstream view of intake space
    int      owed       = 0;             // Cache credits not yet returned
    int      ret_wait   = 0;
    int      beats      = 0;
    int      returned   = 0;
    int      drains     = 0;
    int      cycles     = 0;
    int      limit      = 1000000;
    bit      hold_credits = 0;
    logic [31:0] lfsr   = 32'hf2f7;

    mem_stage_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int pick_delay();
        logic b0;
        logic b1;
        lfsr = lfsr_step(lfsr);
        b0   = lfsr[0];
        lfsr = lfsr_step(lfsr);
        b1   = lfsr[0];
        return int'({b1, b0});           // 0..3 cycles
    endfunction

    task automatic report_fail(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] data,
                           input logic [2:0] f3, input logic [3:0] rob,
                           input logic hit = 1'b0, input logic [31:0] exp = '0,
                           input int after_drains = 0);
        row_t r;
        r = '{op, addr, data, f3, rob, hit, exp, after_drains};
        rows.push_back(r);
    endtask

    task automatic add_idle(input int n);
        repeat (n) add_row(OP_IDLE, '0, '0, 3'b0, 4'd0);
    endtask

    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [2:0] f3);
        wr_exp_t w;
        w = '{addr, data, f3};
        wr_exp.push_back(w);
    endtask

    task automatic build_table();
        // Forwarding, exact address and width
        add_row(OP_STORE, 32'h100, 32'haaaa0001, LS_W, 4'd1);
        add_row(OP_LOAD,  32'h100, '0, LS_W, 4'd0, 1'b1, 32'haaaa0001);
        add_row(OP_LOAD,  32'h100, '0, LS_H, 4'd0, 1'b0, 32'h0);
        add_row(OP_LOAD,  32'h104, '0, LS_W, 4'd0, 1'b0, 32'h0);
        // Youngest match
        add_row(OP_STORE, 32'h200, 32'h11111111, LS_W, 4'd2);
        add_row(OP_STORE, 32'h200, 32'h22222222, LS_W, 4'd3);
        add_row(OP_LOAD,  32'h200, '0, LS_W, 4'd0, 1'b1, 32'h22222222);
        add_idle(3);
        // Commit all three, drain in program order
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd1);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd2);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd3);
        add_write(32'h100, 32'haaaa0001, LS_W);
        add_write(32'h200, 32'h11111111, LS_W);
        add_write(32'h200, 32'h22222222, LS_W);
        add_idle(10);
        // Flush drops the two uncommitted stores
        add_row(OP_STORE, 32'h300, 32'h33333333, LS_W, 4'd4);
        add_row(OP_STORE, 32'h304, 32'h00004444, LS_H, 4'd5);
        add_row(OP_STORE, 32'h308, 32'h00000055, LS_B, 4'd6);
        add_idle(3);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd4);
        add_row(OP_FLUSH,  '0, '0, 3'b0, 4'd0);
        add_row(OP_LOAD,   32'h304, '0, LS_H, 4'd0, 1'b0, 32'h0);
        add_row(OP_LOAD,   32'h308, '0, LS_B, 4'd0, 1'b0, 32'h0);
        add_write(32'h300, 32'h33333333, LS_W);
        add_idle(10);
        // Back-pressure, fifth store waits in intake with a load behind it
        for (int i = 0; i < 5; i++) begin
            add_row(OP_STORE, 32'h400 + 32'(4 * i), 32'h60000001 + 32'(i), LS_W, 4'(7 + i));
        end
        add_row(OP_LOAD, 32'h410, '0, LS_W, 4'd0, 1'b1, 32'h60000005, 5);
        add_idle(4);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd7);
        add_idle(8);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd8);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd9);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd10);
        add_idle(8);
        add_row(OP_COMMIT, '0, '0, 3'b0, 4'd11);
        for (int i = 0; i < 5; i++) begin
            add_write(32'h400 + 32'(4 * i), 32'h60000001 + 32'(i), LS_W);
        end
        add_idle(12);
        // Cache credit starvation, then release
        add_row(OP_HOLD, '0, '0, 3'b0, 4'd0);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_STORE, 32'h500 + 32'(4 * i), 32'h70000001 + 32'(i), LS_W, 4'(12 + i));
            add_write(32'h500 + 32'(4 * i), 32'h70000001 + 32'(i), LS_W);
        end
        add_idle(3);
        for (int i = 0; i < 3; i++) begin
            add_row(OP_COMMIT, '0, '0, 3'b0, 4'(12 + i));
        end
        add_idle(12);
        add_row(OP_RELEASE, '0, '0, 3'b0, 4'd0);
        add_idle(6);
    endtask

    // One clock step; inputs change 1 ns after the edge, cache credits returned here
    task automatic next_cycle();
        @(posedge clk);
        #1;
        req_valid    = 1'b0;
        req_is_store = 1'b0;
        req_is_load  = 1'b0;
        commit_valid = 1'b0;
        flush        = 1'b0;
        cw_credit    = 1'b0;
        if (!hold_credits && owed > 0) begin
            if (ret_wait == 0) begin
                cw_credit = 1'b1;
                owed--;
                ret_wait = pick_delay();
            end else begin
                ret_wait--;
            end
        end
    endtask

    // Output monitors, sampled at the edge
    always @(posedge clk) begin
        if (arst_n) begin
            if (req_credit) up_credits++;
            assert (up_credits <= REQ_Q_DEPTH)
                else report_fail("intake credit returned beyond the queue depth");
            if (ld_valid) begin
                assert (ld_q.size() > 0)
                    else report_fail("load result with no load outstanding");
                assert (ld_hit == ld_q[0].hit && ld_data == ld_q[0].data)
                    else report_fail($sformatf("load hit %0b data %h, expected %0b %h",
                                     ld_hit, ld_data, ld_q[0].hit, ld_q[0].data));
                assert (drains >= ld_q[0].after_drains)
                    else report_fail($sformatf("load returned after %0d drains, needs %0d",
                                     drains, ld_q[0].after_drains));
                void'(ld_q.pop_front());
            end
            if (cw_valid) begin
                assert (wr_idx < wr_exp.size())
                    else report_fail("cache write beyond the expected list");
                assert (cw_addr == wr_exp[wr_idx].addr && cw_data == wr_exp[wr_idx].data
                        && cw_funct3 == wr_exp[wr_idx].f3)
                    else report_fail($sformatf("write %0d got %h %h %0d, expected %h %h %0d",
                                     wr_idx, cw_addr, cw_data, cw_funct3,
                                     wr_exp[wr_idx].addr, wr_exp[wr_idx].data,
                                     wr_exp[wr_idx].f3));
                assert (beats + 1 - returned <= CACHE_CREDITS)
                    else report_fail("cache write sent without a cache credit");
                beats++;
                wr_idx++;
                owed++;
            end
            if (cw_credit) returned++;
            if (dut0.sb_wr0.valid) drains++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run did not complete within %0d cycles", limit);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        row_t r;
        build_table();
        limit = rows.size() * 20 + 200;
        arst_n = 1'b0;
        req_valid = 1'b0;
        req_is_store = 1'b0;
        req_is_load = 1'b0;
        req_addr = '0;
        req_data = '0;
        req_funct3 = '0;
        req_rob_idx = '0;
        commit_valid = 1'b0;
        commit_rob_idx = '0;
        flush = 1'b0;
        cw_credit = 1'b0;
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        foreach (rows[i]) begin
            r = rows[i];
            if (r.op == OP_STORE || r.op == OP_LOAD) begin
                while (up_credits == 0) next_cycle();   // Wait for intake space
                req_valid    = 1'b1;
                req_is_store = (r.op == OP_STORE);
                req_is_load  = (r.op == OP_LOAD);
                req_addr     = r.addr;
                req_data     = r.data;
                req_funct3   = r.f3;
                req_rob_idx  = r.rob;
                up_credits--;
                if (r.op == OP_LOAD) ld_q.push_back('{r.hit, r.exp, r.after_drains});
            end else if (r.op == OP_COMMIT) begin
                commit_valid   = 1'b1;
                commit_rob_idx = r.rob;
            end else if (r.op == OP_FLUSH) begin
                flush = 1'b1;
            end else if (r.op == OP_HOLD) begin
                hold_credits = 1'b1;
            end else if (r.op == OP_RELEASE) begin
                hold_credits = 1'b0;
            end
            next_cycle();
        end
        while (ld_q.size() != 0 || wr_idx != wr_exp.size()) next_cycle();
        repeat (5) next_cycle();                        // Catch late extra beats
        if (ld_q.size() == 0 && wr_idx == wr_exp.size() && up_credits == REQ_Q_DEPTH) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "results or intake credits missing at end of run");
        end
    end

endmodule

/* dv/store_buffer_sva.sv */
`timescale 1ns/1ns

// Occupancy and drain properties of the store buffer
module store_buffer_sva import lsq_pkg::*; (
    input logic                 clk,
    input logic                 arst_n,
    input logic [SB_CNT_W-1:0]  count,
    input logic [SB_DEPTH-1:0]  e_valid,
    input logic [SB_IDX_W-1:0]  tail,
    input logic                 pop_store,
    input logic                 drain,
    input logic [WQ_CRED_W-1:0] wq_credits,
    input logic [SB_DEPTH-1:0]  commit_hit
);

    int n_commits;      // Entries marked by the ROB so far
    int n_drains;       // Entries sent toward the write queue so far

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            n_commits <= 0;
            n_drains  <= 0;
        end else begin
            n_commits <= n_commits + $countones(commit_hit);
            n_drains  <= n_drains + int'(drain);
        end
    end

    // Never more entries than the ring holds
    // Count agrees with the live entry flags
    occupancy_a: assert property (@(posedge clk) disable iff (!arst_n)
        (count <= SB_CNT_W'(SB_DEPTH)) && (int'(count) == $countones(e_valid)))
        else $error("store buffer occupancy above depth or out of step with entry flags");

    // A full ring has no free slot for a store
    free_slot_a: assert property (@(posedge clk) disable iff (!arst_n)
        pop_store |-> !e_valid[tail])
        else $error("store popped into an occupied entry");

    // Write-queue credits never leave the pool
    // A send with zero credits wraps the counter past the pool
    wq_credit_a: assert property (@(posedge clk) disable iff (!arst_n)
        wq_credits <= WQ_CRED_W'(WR_Q_DEPTH))
        else $error("write-queue credit count out of range");

    // Never more drains than ROB commits
    drain_cmt_a: assert property (@(posedge clk) disable iff (!arst_n)
        drain |-> (n_drains < n_commits))
        else $error("entry drained without a matching commit");

endmodule

bind store_buffer store_buffer_sva sva0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .count      (count),
    .e_valid    (e_valid),
    .tail       (tail),
    .pop_store  (pop_store),
    .drain      (drain),
    .wq_credits (wq_credits),
    .commit_hit (commit_hit)
);

/* files.f */
hw/lsq_pkg.sv
hw/sb_wr_if.sv
hw/credit_fifo.sv
hw/store_buffer.sv
hw/cache_write_port.sv
hw/mem_stage_top.sv
dv/store_buffer_sva.sv
dv/mem_stage_tb.sv

/* hw/cache_write_port.sv */
`timescale 1ns/1ns

// Write queue toward the D-cache, sends one write per cache credit
module cache_write_port import lsq_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    sb_wr_if.wp             wr,
    output logic            cw_valid,
    output logic [XLEN-1:0] cw_addr,
    output logic [XLEN-1:0] cw_data,
    output logic [2:0]      cw_funct3,
    input  logic            cw_credit       // One write slot returned by the cache
);

    cache_wr_t            wq_in;
    cache_wr_t            wq_head;
    logic                 wq_valid;
    logic                 wq_pop;
    logic [CC_CRED_W-1:0] cc_credits;       // Writes the cache can still take

    assign wq_in = '{addr: wr.addr, data: wr.data, width: wr.funct3};

    // Queue credits go straight back to the store buffer
    credit_fifo #(
        .DEPTH     (WR_Q_DEPTH),
        .payload_t (cache_wr_t)
    ) wq0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (wr.valid),
        .in_payload  (wq_in),
        .credit      (wr.credit),
        .out_valid   (wq_valid),
        .out_payload (wq_head),
        .pop         (wq_pop)
    );

    assign wq_pop = wq_valid && (cc_credits != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cw_valid   <= 1'b0;
            cc_credits <= CC_CRED_W'(CACHE_CREDITS);
        end else begin
            cw_valid   <= wq_pop;                       // Registered send
            cc_credits <= cc_credits + CC_CRED_W'(cw_credit) - CC_CRED_W'(wq_pop);
        end
    end

    // Write payload, held between sends
    always_ff @(posedge clk) begin
        if (wq_pop) begin
            cw_addr   <= wq_head.addr;
            cw_data   <= wq_head.data;
            cw_funct3 <= wq_head.width;
        end
    end

endmodule

/* hw/credit_fifo.sv */
`timescale 1ns/1ns

// Circular queue behind a credit-managed sender
// Sender holds DEPTH credits at reset, so a push never finds the queue full
module credit_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,       // Push, only with a credit held upstream
    input  payload_t in_payload,
    output logic     credit,         // One pulse per popped slot
    output logic     out_valid,      // Head present
    output payload_t out_payload,    // Head entry
    input  logic     pop             // Same-cycle removal of the head
);

    payload_t                   mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       pop_ok;

    assign out_valid   = (count != '0);
    assign out_payload = mem[rd_ptr];
    assign pop_ok      = pop && out_valid;      // Pop on empty is ignored

    // Pointers, occupancy and the registered credit pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            credit <= pop_ok;                   // Slot returned one cycle after the pop
            if (in_valid) begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Both or neither
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_payload;
        end
    end

endmodule

/* hw/lsq_pkg.sv */
package lsq_pkg;

    // Datapath and ROB sizing
    localparam int XLEN          = 32;
    localparam int ROB_IDX_W     = 4;

    // Queue depths and credit pools
    localparam int SB_DEPTH      = 4;                       // Store buffer entries
    localparam int REQ_Q_DEPTH   = 4;                       // Intake slots, upstream credits
    localparam int WR_Q_DEPTH    = 2;                       // Write queue slots, sb credits
    localparam int CACHE_CREDITS = 2;                       // Granted by the D-cache

    // Derived widths
    localparam int SB_IDX_W      = $clog2(SB_DEPTH);        // Ring pointer
    localparam int SB_CNT_W      = $clog2(SB_DEPTH + 1);    // Occupancy, 0..SB_DEPTH
    localparam int WQ_CRED_W     = $clog2(WR_Q_DEPTH + 1);
    localparam int CC_CRED_W     = $clog2(CACHE_CREDITS + 1);

    // RV32 load/store funct3 encodings
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_width_e;

    // One memory-stage request as it sits in the intake queue
    typedef struct packed {
        logic                 is_store;
        logic                 is_load;
        logic [XLEN-1:0]      addr;
        logic [XLEN-1:0]      data;
        ls_width_e            width;
        logic [ROB_IDX_W-1:0] rob_idx;
    } mem_req_t;

    // Drained store on its way to the cache
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
        ls_width_e       width;
    } cache_wr_t;

endpackage

/* hw/mem_stage_top.sv */
`timescale 1ns/1ns

// Memory-stage store path: intake queue, store buffer, cache write port
module mem_stage_top import lsq_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    // Upstream requests, credit based
    input  logic                 req_valid,
    input  logic                 req_is_store,
    input  logic                 req_is_load,
    input  logic [XLEN-1:0]      req_addr,
    input  logic [XLEN-1:0]      req_data,
    input  logic [2:0]           req_funct3,
    input  logic [ROB_IDX_W-1:0] req_rob_idx,
    output logic                 req_credit,
    // ROB
    input  logic                 commit_valid,
    input  logic [ROB_IDX_W-1:0] commit_rob_idx,
    input  logic                 flush,
    // Load result
    output logic                 ld_valid,
    output logic                 ld_hit,
    output logic [XLEN-1:0]      ld_data,
    // D-cache write port
    output logic                 cw_valid,
    output logic [XLEN-1:0]      cw_addr,
    output logic [XLEN-1:0]      cw_data,
    output logic [2:0]           cw_funct3,
    input  logic                 cw_credit
);

    mem_req_t req_in;           // Packed request into intake
    mem_req_t rq_head;          // Intake head
    logic     rq_valid;
    logic     rq_pop;

    sb_wr_if  sb_wr0 ();        // Store buffer to write port

    assign req_in.is_store = req_is_store;
    assign req_in.is_load  = req_is_load;
    assign req_in.addr     = req_addr;
    assign req_in.data     = req_data;
    assign req_in.width    = ls_width_e'(req_funct3);
    assign req_in.rob_idx  = req_rob_idx;

    // Intake queue, upstream holds REQ_Q_DEPTH credits at reset
    credit_fifo #(
        .DEPTH     (REQ_Q_DEPTH),
        .payload_t (mem_req_t)
    ) rq0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (req_valid),
        .in_payload  (req_in),
        .credit      (req_credit),
        .out_valid   (rq_valid),
        .out_payload (rq_head),
        .pop         (rq_pop)
    );

    store_buffer sb0 (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (rq_valid),
        .req            (rq_head),
        .pop            (rq_pop),
        .commit_valid   (commit_valid),
        .commit_rob_idx (commit_rob_idx),
        .flush          (flush),
        .ld_valid       (ld_valid),
        .ld_hit         (ld_hit),
        .ld_data        (ld_data),
        .wr             (sb_wr0.sb)
    );

    cache_write_port wp0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (sb_wr0.wp),
        .cw_valid  (cw_valid),
        .cw_addr   (cw_addr),
        .cw_data   (cw_data),
        .cw_funct3 (cw_funct3),
        .cw_credit (cw_credit)
    );

endmodule

/* hw/sb_wr_if.sv */
`timescale 1ns/1ns

// Drained-store channel, credit based
// One beat per cycle with valid high; one credit pulse per freed write-queue slot
interface sb_wr_if import lsq_pkg::*; ();

    logic            valid;     // Store beat present
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    ls_width_e       funct3;    // Access width, RV32 encoding
    logic            credit;    // Slot freed in the write queue

    // Store buffer side
    modport sb (
        output valid,
        output addr,
        output data,
        output funct3,
        input  credit
    );

    // Write port side
    modport wp (
        input  valid,
        input  addr,
        input  data,
        input  funct3,
        output credit
    );

endinterface

/* hw/store_buffer.sv */
`timescale 1ns/1ns

// Speculative store buffer, SB_DEPTH entries kept in program order
// Stores wait here until the ROB commits them, then drain oldest first
module store_buffer import lsq_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,         // Intake head present
    input  mem_req_t             req,               // Intake head
    output logic                 pop,               // Take the head this cycle
    input  logic                 commit_valid,
    input  logic [ROB_IDX_W-1:0] commit_rob_idx,
    input  logic                 flush,
    output logic                 ld_valid,
    output logic                 ld_hit,
    output logic [XLEN-1:0]      ld_data,
    sb_wr_if.sb                  wr
);

    // Entry state, control bits as vectors
    logic [SB_DEPTH-1:0]  e_valid;
    logic [SB_DEPTH-1:0]  e_cmt;                    // Committed by the ROB
    logic [XLEN-1:0]      e_addr [SB_DEPTH];
    logic [XLEN-1:0]      e_data [SB_DEPTH];
    ls_width_e            e_width [SB_DEPTH];
    logic [ROB_IDX_W-1:0] e_rob [SB_DEPTH];

    logic [SB_IDX_W-1:0]  head;                     // Oldest entry
    logic [SB_IDX_W-1:0]  tail;                     // Next free slot
    logic [SB_CNT_W-1:0]  count;
    logic [WQ_CRED_W-1:0] wq_credits;               // Free write-queue slots

    logic                 full;
    logic                 pop_store;
    logic                 pop_load;
    logic                 drain;
    logic [SB_DEPTH-1:0]  commit_hit;
    logic [SB_CNT_W-1:0]  n_cmt;                    // Committed entries after this edge
    logic [SB_DEPTH-1:0]  valid_nxt;
    logic [SB_DEPTH-1:0]  cmt_nxt;
    logic [SB_IDX_W-1:0]  scan_idx;
    logic                 fwd_hit;
    logic [XLEN-1:0]      fwd_data;

    assign full = (count == SB_CNT_W'(SB_DEPTH));

    // Loads always go, stores need a free entry; nothing moves in a flush cycle
    assign pop       = req_valid && !flush && (!req.is_store || !full);
    assign pop_store = pop && req.is_store;
    assign pop_load  = pop && req.is_load && !req.is_store;

    // Committed head leaves when a write-queue slot is free
    assign drain = e_valid[head] && e_cmt[head] && (wq_credits != '0);

    // ROB commit lookup, ROB indices are unique among live stores
    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            commit_hit[i] = commit_valid && e_valid[i] && !e_cmt[i]
                            && (e_rob[i] == commit_rob_idx);
        end
    end

    // Count of entries that survive a flush, the drained one included
    always_comb begin
        n_cmt = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (e_valid[i] && (e_cmt[i] || commit_hit[i])) begin
                n_cmt = n_cmt + 1'b1;
            end
        end
    end

    // Next valid and committed flags
    always_comb begin
        valid_nxt = e_valid;
        cmt_nxt   = e_cmt | commit_hit;             // Commit lands before a same-cycle flush
        if (drain) begin
            valid_nxt[head] = 1'b0;
            cmt_nxt[head]   = 1'b0;
        end
        if (flush) begin
            valid_nxt = valid_nxt & cmt_nxt;        // Drop every speculative store
        end else if (pop_store) begin
            valid_nxt[tail] = 1'b1;                 // New entry starts uncommitted
            cmt_nxt[tail]   = 1'b0;
        end
    end

    // Forwarding search, youngest entry first, exact address and width only
    always_comb begin
        fwd_hit  = 1'b0;
        fwd_data = '0;
        scan_idx = tail;
        for (int k = 1; k <= SB_DEPTH; k++) begin
            scan_idx = tail - SB_IDX_W'(k);
            if (!fwd_hit && e_valid[scan_idx] && (e_addr[scan_idx] == req.addr)
                && (e_width[scan_idx] == req.width)) begin
                fwd_hit  = 1'b1;
                fwd_data = e_data[scan_idx];
            end
        end
    end

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid    <= '0;
            e_cmt      <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            wq_credits <= WQ_CRED_W'(WR_Q_DEPTH);
            wr.valid   <= 1'b0;
            ld_valid   <= 1'b0;
        end else begin
            e_valid  <= valid_nxt;
            e_cmt    <= cmt_nxt;
            ld_valid <= pop_load;                   // Result one edge after the pop
            wr.valid <= drain;
            if (drain) begin
                head <= head + 1'b1;
            end
            if (flush) begin
                // Committed entries sit at the head, so the tail lands just past them
                tail  <= head + n_cmt[SB_IDX_W-1:0];
                count <= n_cmt - SB_CNT_W'(drain);
            end else begin
                if (pop_store) begin
                    tail <= tail + 1'b1;
                end
                count <= count + SB_CNT_W'(pop_store) - SB_CNT_W'(drain);
            end
            wq_credits <= wq_credits + WQ_CRED_W'(wr.credit) - WQ_CRED_W'(drain);
        end
    end

    // Entry payload, load result and drain beat
    always_ff @(posedge clk) begin
        if (pop_store) begin
            e_addr[tail]  <= req.addr;
            e_data[tail]  <= req.data;
            e_width[tail] <= req.width;
            e_rob[tail]   <= req.rob_idx;
        end
        ld_hit  <= fwd_hit;
        ld_data <= fwd_data;                        // Zero on a miss
        if (drain) begin
            wr.addr   <= e_addr[head];
            wr.data   <= e_data[head];
            wr.funct3 <= e_width[head];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the memory-stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f files.f \
    --top-module mem_stage_tb \
    -o mem_stage_sim

./obj_dir/mem_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
else
    exit 1
fi
